//--- design/soc_pkg.sv
// Shared widths, page map, register offsets and bus types
// Address layout is page[15:12], word offset[11:2], byte lane[1:0]
// Byte lane bits are not decoded; every access is word aligned
package soc_pkg;

	// ----------------------------------------
	// Bus widths
	// ----------------------------------------
	localparam int ADDR_W = 16;
	localparam int DATA_W = 32;
	localparam int SEL_W  = DATA_W / 8;
	localparam int LANE_W = $clog2(SEL_W);
	localparam int PAGE_W = 4;
	localparam int OFFS_W = 10;

	// ----------------------------------------
	// Page map
	// ----------------------------------------
	localparam logic [PAGE_W-1:0] PAGE_BRAM  = 4'd0;
	localparam logic [PAGE_W-1:0] PAGE_TIMER = 4'd7;
	localparam logic [PAGE_W-1:0] PAGE_GPIO  = 4'd8;

	// Timer register word offsets
	localparam logic [OFFS_W-1:0] TMR_CTRL    = 10'd0;
	localparam logic [OFFS_W-1:0] TMR_COMPARE = 10'd1;
	localparam logic [OFFS_W-1:0] TMR_COUNT   = 10'd2;
	localparam logic [OFFS_W-1:0] TMR_STATUS  = 10'd3;

	// GPIO register word offsets
	localparam logic [OFFS_W-1:0] GPIO_IN   = 10'd0;
	localparam logic [OFFS_W-1:0] GPIO_OUT  = 10'd1;
	localparam logic [OFFS_W-1:0] GPIO_MASK = 10'd2;

	// Interrupt vector, active high
	localparam int IRQ_W     = 2;
	localparam int IRQ_TIMER = 0;
	localparam int IRQ_GPIO  = 1;
	localparam int GPIO_W    = 8;

	// One strobe bit per peripheral
	localparam int NUM_SLV = 3;

	// ----------------------------------------
	// Types
	// ----------------------------------------
	// Master request, 53 bits
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [SEL_W-1:0]  sel;
		logic              we;
	} bus_req_t;

	// Response to the master, 33 bits
	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic              err;
	} bus_rsp_t;

	// What a peripheral sees, page already stripped
	typedef struct packed {
		logic [OFFS_W-1:0] offs;
		logic [DATA_W-1:0] wdata;
		logic [SEL_W-1:0]  sel;
		logic              we;
	} slv_req_t;

	typedef enum logic [1:0] {
		SLV_BRAM  = 2'd0,
		SLV_TIMER = 2'd1,
		SLV_GPIO  = 2'd2
	} slv_idx_e;

	typedef logic [IRQ_W-1:0] irq_t;

endpackage

//--- design/credit_fifo.sv
// Registered FIFO with credit flow control on both sides
// Upstream must push only while it holds one of the DEPTH credits
// Downstream starts with INIT_CREDITS and returns them on credit_i
`timescale 1ns/1ps

module credit_fifo #(
	parameter type payload_t    = logic,
	parameter int  DEPTH        = 4,
	parameter int  INIT_CREDITS = 4
) (
	input  logic     clk,
	input  logic     arst_n_i,
	input  logic     push_i,
	input  payload_t push_data_i,
	output logic     credit_o,
	input  logic     credit_i,
	output logic     out_valid_o,
	output payload_t out_data_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	// Headroom bit so an extra credit shows up in the check
	localparam int CRD_W = $clog2(INIT_CREDITS + 2);

	payload_t             mem [DEPTH];
	logic [PTR_W-1:0]     wr_ptr_q;
	logic [PTR_W-1:0]     rd_ptr_q;
	logic [CNT_W-1:0]     count_q;
	logic [CRD_W-1:0]     credit_q;
	logic                 send;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// Head leaves whenever downstream has room
	assign send        = (count_q != '0) && (credit_q != '0);
	assign out_valid_o = send;
	assign out_data_o  = mem[rd_ptr_q];
	// A freed entry goes straight back upstream as a credit
	assign credit_o    = send;

	always_ff @(posedge clk) begin
		if (push_i)
			mem[wr_ptr_q] <= push_data_i;
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			credit_q <= CRD_W'(INIT_CREDITS);
		end else begin
			if (push_i)
				wr_ptr_q <= ptr_next(wr_ptr_q);
			if (send)
				rd_ptr_q <= ptr_next(rd_ptr_q);
			case ({push_i, send})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: ;
			endcase
			case ({credit_i, send})
				2'b10:   credit_q <= credit_q + 1'b1;
				2'b01:   credit_q <= credit_q - 1'b1;
				default: ;
			endcase
		end
	end

	// Upstream kept to its credit budget
	a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n_i)
		push_i |-> (count_q < CNT_W'(DEPTH)))
		else $error("push into full buffer");

	// Downstream never returns more than it was lent
	a_credit_max: assert property (@(posedge clk) disable iff (!arst_n_i)
		credit_q <= CRD_W'(INIT_CREDITS))
		else $error("credit counter above initial value");

endmodule

//--- design/page_router.sv
// Two-stage page decoder, never stalls
// Caller guarantees a response slot for every accepted request
// Peripherals must return read data exactly one cycle after their strobe
`timescale 1ns/1ps

module page_router (
	input  logic                          clk,
	input  logic                          arst_n_i,
	input  logic                          in_valid_i,
	input  soc_pkg::bus_req_t             in_req_i,
	output soc_pkg::slv_req_t             slv_req_o,
	output logic [soc_pkg::NUM_SLV-1:0]   slv_stb_o,
	input  logic [soc_pkg::DATA_W-1:0]    bram_rdata_i,
	input  logic [soc_pkg::DATA_W-1:0]    tmr_rdata_i,
	input  logic [soc_pkg::DATA_W-1:0]    gpio_rdata_i,
	output logic                          out_valid_o,
	output soc_pkg::bus_rsp_t             out_rsp_o
);

	import soc_pkg::*;

	logic [PAGE_W-1:0]  in_page;
	slv_idx_e           dec_idx;
	logic               dec_hit;

	// Stage one
	logic               s1_valid_q;
	logic [NUM_SLV-1:0] s1_stb_q;
	slv_req_t           s1_req_q;
	slv_idx_e           s1_idx_q;
	logic               s1_err_q;

	// Stage two
	logic               s2_valid_q;
	slv_idx_e           s2_idx_q;
	logic               s2_err_q;
	logic               s2_we_q;
	logic [DATA_W-1:0]  sel_rdata;

	assign in_page = in_req_i.addr[ADDR_W-1 -: PAGE_W];

	always_comb begin
		dec_idx = SLV_BRAM;
		dec_hit = 1'b1;
		case (in_page)
			PAGE_BRAM:  dec_idx = SLV_BRAM;
			PAGE_TIMER: dec_idx = SLV_TIMER;
			PAGE_GPIO:  dec_idx = SLV_GPIO;
			default:    dec_hit = 1'b0;
		endcase
	end

	// ----------------------------------------
	// Stage one: register and strobe
	// ----------------------------------------
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			s1_valid_q <= 1'b0;
			s1_stb_q   <= '0;
		end else begin
			s1_valid_q <= in_valid_i;
			// Unmapped page strobes nobody
			s1_stb_q   <= (in_valid_i && dec_hit) ? (NUM_SLV'(1) << dec_idx) : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid_i) begin
			s1_req_q.offs  <= in_req_i.addr[LANE_W +: OFFS_W];
			s1_req_q.wdata <= in_req_i.wdata;
			s1_req_q.sel   <= in_req_i.sel;
			s1_req_q.we    <= in_req_i.we;
			s1_idx_q       <= dec_idx;
			s1_err_q       <= !dec_hit;
		end
	end

	assign slv_req_o = s1_req_q;
	assign slv_stb_o = s1_stb_q;

	// ----------------------------------------
	// Stage two: collect read data
	// ----------------------------------------
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			s2_valid_q <= 1'b0;
		else
			s2_valid_q <= s1_valid_q;
	end

	always_ff @(posedge clk) begin
		if (s1_valid_q) begin
			s2_idx_q <= s1_idx_q;
			s2_err_q <= s1_err_q;
			s2_we_q  <= s1_req_q.we;
		end
	end

	always_comb begin
		case (s2_idx_q)
			SLV_BRAM:  sel_rdata = bram_rdata_i;
			SLV_TIMER: sel_rdata = tmr_rdata_i;
			SLV_GPIO:  sel_rdata = gpio_rdata_i;
			default:   sel_rdata = '0;
		endcase
		out_rsp_o.err   = s2_err_q;
		// Errors and writes carry no data
		out_rsp_o.rdata = (s2_err_q || s2_we_q) ? '0 : sel_rdata;
	end

	assign out_valid_o = s2_valid_q;

	// At most one peripheral strobed
	a_stb_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
		$onehot0(slv_stb_o))
		else $error("bad strobe vector");

endmodule

//--- design/bram_slave.sv
// Word addressed block RAM, contents undefined after power up
// Offsets wrap modulo BRAM_WORDS, at most 2**OFFS_W words
// Read data is valid the cycle after the strobe only
`timescale 1ns/1ps

module bram_slave #(
	parameter int BRAM_WORDS = 256
) (
	input  logic                       clk,
	input  logic                       stb_i,
	input  soc_pkg::slv_req_t          req_i,
	output logic [soc_pkg::DATA_W-1:0] rdata_o
);

	import soc_pkg::*;

	localparam int IDX_W = (BRAM_WORDS > 1) ? $clog2(BRAM_WORDS) : 1;

	logic [DATA_W-1:0] mem [BRAM_WORDS];
	logic [OFFS_W-1:0] wrap_offs;
	logic [IDX_W-1:0]  idx;
	logic [DATA_W-1:0] rdata_q;

	// Fold the page offset onto the array
	assign wrap_offs = OFFS_W'(int'(req_i.offs) % BRAM_WORDS);
	assign idx       = wrap_offs[IDX_W-1:0];

	// ----------------------------------------
	// Byte lane writes
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (stb_i && req_i.we) begin
			for (int b = 0; b < SEL_W; b++) begin
				if (req_i.sel[b])
					mem[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
			end
		end
	end

	// Registered read, old word on a write strobe
	always_ff @(posedge clk) begin
		if (stb_i)
			rdata_q <= mem[idx];
	end

	assign rdata_o = rdata_q;

endmodule

//--- design/timer_slave.sv
// Compare timer, full word register writes, byte selects ignored
// Counter wraps to zero on match and sets a sticky status
// Lowering compare below the count lets the count run to its own wrap
`timescale 1ns/1ps

module timer_slave (
	input  logic                       clk,
	input  logic                       arst_n_i,
	input  logic                       stb_i,
	input  soc_pkg::slv_req_t          req_i,
	output logic [soc_pkg::DATA_W-1:0] rdata_o,
	output logic                       irq_o
);

	import soc_pkg::*;

	logic              en_q;
	logic [DATA_W-1:0] compare_q;
	logic [DATA_W-1:0] count_q;
	logic              status_q;
	logic [DATA_W-1:0] rdata_q;
	logic              wr;
	logic              hit;

	assign wr  = stb_i && req_i.we;
	assign hit = en_q && (count_q == compare_q);

	// ----------------------------------------
	// Control, compare and counter
	// ----------------------------------------
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			en_q      <= 1'b0;
			compare_q <= '0;
			count_q   <= '0;
			status_q  <= 1'b0;
		end else begin
			if (wr && req_i.offs == TMR_CTRL)
				en_q <= req_i.wdata[0];
			if (wr && req_i.offs == TMR_COMPARE)
				compare_q <= req_i.wdata;

			if (hit)
				count_q <= '0;
			else if (en_q)
				count_q <= count_q + 1'b1;

			// Any write clears, a match in the same cycle still wins
			if (wr && req_i.offs == TMR_STATUS)
				status_q <= 1'b0;
			if (hit)
				status_q <= 1'b1;
		end
	end

	// ----------------------------------------
	// Read back
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (stb_i) begin
			case (req_i.offs)
				TMR_CTRL:    rdata_q <= DATA_W'(en_q);
				TMR_COMPARE: rdata_q <= compare_q;
				TMR_COUNT:   rdata_q <= count_q;
				TMR_STATUS:  rdata_q <= DATA_W'(status_q);
				default:     rdata_q <= '0;
			endcase
		end
	end

	assign rdata_o = rdata_q;
	// Level interrupt straight from the sticky bit
	assign irq_o   = status_q;

endmodule

//--- design/gpio_slave.sv
// 8-bit GPIO with one input sampling register, no metastability filter
// OUT and MASK take wdata[7:0] under byte select 0
// Interrupt is a level, high while any unmasked input is high
`timescale 1ns/1ps

module gpio_slave (
	input  logic                       clk,
	input  logic                       arst_n_i,
	input  logic                       stb_i,
	input  soc_pkg::slv_req_t          req_i,
	output logic [soc_pkg::DATA_W-1:0] rdata_o,
	input  logic [soc_pkg::GPIO_W-1:0] gpio_in_i,
	output logic [soc_pkg::GPIO_W-1:0] gpio_out_o,
	output logic                       irq_o
);

	import soc_pkg::*;

	logic [GPIO_W-1:0] in_q;
	logic [GPIO_W-1:0] out_q;
	logic [GPIO_W-1:0] mask_q;
	logic              irq_q;
	logic [DATA_W-1:0] rdata_q;
	logic              wr_lo;

	assign wr_lo = stb_i && req_i.we && req_i.sel[0];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			in_q   <= '0;
			out_q  <= '0;
			mask_q <= '0;
			irq_q  <= 1'b0;
		end else begin
			in_q  <= gpio_in_i;
			irq_q <= |(in_q & mask_q);
			if (wr_lo && req_i.offs == GPIO_OUT)
				out_q <= req_i.wdata[GPIO_W-1:0];
			if (wr_lo && req_i.offs == GPIO_MASK)
				mask_q <= req_i.wdata[GPIO_W-1:0];
		end
	end

	// Read back, upper bits zero
	always_ff @(posedge clk) begin
		if (stb_i) begin
			case (req_i.offs)
				GPIO_IN:   rdata_q <= DATA_W'(in_q);
				GPIO_OUT:  rdata_q <= DATA_W'(out_q);
				GPIO_MASK: rdata_q <= DATA_W'(mask_q);
				default:   rdata_q <= '0;
			endcase
		end
	end

	assign rdata_o    = rdata_q;
	assign gpio_out_o = out_q;
	assign irq_o      = irq_q;

endmodule

//--- design/soc_bus_top.sv
// Bus side of the SoC for one credit based master
// Master starts with REQ_DEPTH request credits, the SoC with 2 response credits
// Responses return in request order
`timescale 1ns/1ps

module soc_bus_top #(
	parameter int REQ_DEPTH  = 4,
	parameter int RSP_DEPTH  = 4,
	parameter int BRAM_WORDS = 256
) (
	input  logic                       clk,
	input  logic                       arst_n_i,
	input  logic                       req_valid_i,
	input  soc_pkg::bus_req_t          req_i,
	output logic                       req_credit_o,
	output logic                       rsp_valid_o,
	output soc_pkg::bus_rsp_t          rsp_o,
	input  logic                       rsp_credit_i,
	input  logic [soc_pkg::GPIO_W-1:0] gpio_in_i,
	output logic [soc_pkg::GPIO_W-1:0] gpio_out_o,
	output soc_pkg::irq_t              irq_o
);

	import soc_pkg::*;

	localparam int RSP_CREDITS = 2;

	logic               rtr_in_valid;
	bus_req_t           rtr_in_req;
	logic               rtr_out_valid;
	bus_rsp_t           rtr_out_rsp;
	// Response slot freed, lent back to the request buffer
	logic               rsp_slot_free;
	slv_req_t           slv_req;
	logic [NUM_SLV-1:0] slv_stb;
	logic [DATA_W-1:0]  bram_rdata;
	logic [DATA_W-1:0]  tmr_rdata;
	logic [DATA_W-1:0]  gpio_rdata;

	// ----------------------------------------
	// Request side
	// ----------------------------------------
	credit_fifo #(
		.payload_t    (bus_req_t),
		.DEPTH        (REQ_DEPTH),
		.INIT_CREDITS (RSP_DEPTH)
	) u_req_buf (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.push_i      (req_valid_i),
		.push_data_i (req_i),
		.credit_o    (req_credit_o),
		.credit_i    (rsp_slot_free),
		.out_valid_o (rtr_in_valid),
		.out_data_o  (rtr_in_req)
	);

	page_router u_router (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.in_valid_i   (rtr_in_valid),
		.in_req_i     (rtr_in_req),
		.slv_req_o    (slv_req),
		.slv_stb_o    (slv_stb),
		.bram_rdata_i (bram_rdata),
		.tmr_rdata_i  (tmr_rdata),
		.gpio_rdata_i (gpio_rdata),
		.out_valid_o  (rtr_out_valid),
		.out_rsp_o    (rtr_out_rsp)
	);

	// ----------------------------------------
	// Peripherals
	// ----------------------------------------
	bram_slave #(
		.BRAM_WORDS (BRAM_WORDS)
	) u_bram (
		.clk     (clk),
		.stb_i   (slv_stb[SLV_BRAM]),
		.req_i   (slv_req),
		.rdata_o (bram_rdata)
	);

	timer_slave u_timer (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.stb_i    (slv_stb[SLV_TIMER]),
		.req_i    (slv_req),
		.rdata_o  (tmr_rdata),
		.irq_o    (irq_o[IRQ_TIMER])
	);

	gpio_slave u_gpio (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.stb_i      (slv_stb[SLV_GPIO]),
		.req_i      (slv_req),
		.rdata_o    (gpio_rdata),
		.gpio_in_i  (gpio_in_i),
		.gpio_out_o (gpio_out_o),
		.irq_o      (irq_o[IRQ_GPIO])
	);

	// ----------------------------------------
	// Response side
	// ----------------------------------------
	credit_fifo #(
		.payload_t    (bus_rsp_t),
		.DEPTH        (RSP_DEPTH),
		.INIT_CREDITS (RSP_CREDITS)
	) u_rsp_buf (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.push_i      (rtr_out_valid),
		.push_data_i (rtr_out_rsp),
		.credit_o    (rsp_slot_free),
		.credit_i    (rsp_credit_i),
		.out_valid_o (rsp_valid_o),
		.out_data_o  (rsp_o)
	);

endmodule

//--- dv/soc_tb_model.svh
// Reference model, included inside the testbench module body
// Needs soc_pkg imported and BRAM_WORDS declared before the include
// Timer STATUS reads model as zero, only valid after a clear with the timer off
// Timer COUNT is never read, its value depends on exact timing
`ifndef SOC_TB_MODEL_SVH
`define SOC_TB_MODEL_SVH

logic [DATA_W-1:0] mem_m [BRAM_WORDS];
logic [GPIO_W-1:0] gpio_in_m;
logic [GPIO_W-1:0] gpio_out_m;
logic [GPIO_W-1:0] gpio_mask_m;
logic [DATA_W-1:0] tmr_compare_m;
logic              tmr_en_m;
// Expected responses in issue order
bus_rsp_t          exp_q [$];

// ----------------------------------------
// Register model
// ----------------------------------------
task automatic model_reset();
	gpio_in_m     = '0;
	gpio_out_m    = '0;
	gpio_mask_m   = '0;
	tmr_compare_m = '0;
	tmr_en_m      = 1'b0;
endtask

// Applies one request and returns its response
function automatic bus_rsp_t model_access(input bus_req_t r);
	logic [PAGE_W-1:0] page;
	logic [OFFS_W-1:0] offs;
	int                idx;
	bus_rsp_t          rsp;
	// Page in the top nibble, word offset above the two lane bits
	page = r.addr[15:12];
	offs = r.addr[11:2];
	idx  = offs % BRAM_WORDS;
	rsp  = '0;
	case (page)
		PAGE_BRAM: begin
			if (r.we) begin
				for (int b = 0; b < SEL_W; b++) begin
					if (r.sel[b])
						mem_m[idx][b*8 +: 8] = r.wdata[b*8 +: 8];
				end
			end else begin
				rsp.rdata = mem_m[idx];
			end
		end
		PAGE_TIMER: begin
			// Full word writes, selects ignored
			if (r.we && offs == TMR_CTRL)
				tmr_en_m = r.wdata[0];
			if (r.we && offs == TMR_COMPARE)
				tmr_compare_m = r.wdata;
			if (offs == TMR_CTRL)
				rsp.rdata = DATA_W'(tmr_en_m);
			if (offs == TMR_COMPARE)
				rsp.rdata = tmr_compare_m;
		end
		PAGE_GPIO: begin
			if (r.we && r.sel[0] && offs == GPIO_OUT)
				gpio_out_m = r.wdata[GPIO_W-1:0];
			if (r.we && r.sel[0] && offs == GPIO_MASK)
				gpio_mask_m = r.wdata[GPIO_W-1:0];
			case (offs)
				GPIO_IN:   rsp.rdata = DATA_W'(gpio_in_m);
				GPIO_OUT:  rsp.rdata = DATA_W'(gpio_out_m);
				GPIO_MASK: rsp.rdata = DATA_W'(gpio_mask_m);
				default:   rsp.rdata = '0;
			endcase
		end
		default: rsp.err = 1'b1;
	endcase
	// Writes and errors carry no data
	if (r.we || rsp.err)
		rsp.rdata = '0;
	return rsp;
endfunction

// ----------------------------------------
// Compare tasks
// ----------------------------------------
task automatic check_rsp(input bus_rsp_t got);
	bus_rsp_t exp;
	if (exp_q.size() == 0) begin
		stop_on_error("response arrived with no request outstanding");
	end else begin
		exp = exp_q.pop_front();
		if (got !== exp)
			stop_on_error($sformatf("ERR rsp_o rdata exp=%h got=%h err exp=%h got=%h",
				exp.rdata, got.rdata, exp.err, got.err));
	end
endtask

task automatic check_irq(input irq_t got, input irq_t exp);
	if (got !== exp)
		stop_on_error($sformatf("ERR irq_o exp=%h got=%h", exp, got));
endtask

task automatic check_gpio(input logic [GPIO_W-1:0] got, input logic [GPIO_W-1:0] exp);
	if (got !== exp)
		stop_on_error($sformatf("ERR gpio_out_o exp=%h got=%h", exp, got));
endtask

`endif

//--- dv/soc_tb.sv
// Testbench for soc_bus_top with one credit based master
// Random RAM traffic, unmapped pages, GPIO and timer sequences
// Response credits are withheld in random stretches
// Stops at the first mismatch
`timescale 1ns/1ps

module soc_tb;

	import soc_pkg::*;

	localparam int REQ_DEPTH   = 4;
	localparam int RSP_DEPTH   = 4;
	localparam int BRAM_WORDS  = 256;
	// Response credits the DUT starts with
	localparam int RSP_CREDITS = 2;
	localparam int NUM_RAND    = 600;

	logic              clk;
	logic              arst_n_i;
	logic              req_valid_i;
	bus_req_t          req_i;
	logic              req_credit_o;
	logic              rsp_valid_o;
	bus_rsp_t          rsp_o;
	logic              rsp_credit_i;
	logic [GPIO_W-1:0] gpio_in_i;
	logic [GPIO_W-1:0] gpio_out_o;
	irq_t              irq_o;

	logic [15:0] lfsr;
	int          req_credits;
	// Responses seen minus credits the DUT has taken back
	int          rsp_debt;
	// Credits still to hand back
	int          owed;
	int          stall_left;
	int          issued;
	int          cycles;
	logic        credit_prev;

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1, "stopped at first error");
	endtask

	`include "soc_tb_model.svh"

	soc_bus_top #(
		.REQ_DEPTH  (REQ_DEPTH),
		.RSP_DEPTH  (RSP_DEPTH),
		.BRAM_WORDS (BRAM_WORDS)
	) DUT (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.req_valid_i  (req_valid_i),
		.req_i        (req_i),
		.req_credit_o (req_credit_o),
		.rsp_valid_o  (rsp_valid_o),
		.rsp_o        (rsp_o),
		.rsp_credit_i (rsp_credit_i),
		.gpio_in_i    (gpio_in_i),
		.gpio_out_o   (gpio_out_o),
		.irq_o        (irq_o)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// Taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rnd_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// ----------------------------------------
	// Per cycle drive, credit return policy
	// ----------------------------------------
	task automatic step_cycle(input logic valid, input bus_req_t r);
		@(posedge clk);
		req_valid_i <= valid;
		req_i       <= r;
		gpio_in_i   <= gpio_in_m;
		if (stall_left > 0) begin
			stall_left--;
			rsp_credit_i <= 1'b0;
		end else if (rnd_bits(6) == 0) begin
			// Start a stretch with no credits back
			stall_left = 8 + rnd_bits(5);
			rsp_credit_i <= 1'b0;
		end else if (owed > 0 && rnd_bits(1) == 1) begin
			owed--;
			rsp_credit_i <= 1'b1;
		end else begin
			rsp_credit_i <= 1'b0;
		end
	endtask

	// Waits for a request credit, then spends it
	task automatic issue(input bus_req_t r);
		while (req_credits == 0)
			step_cycle(1'b0, '0);
		exp_q.push_back(model_access(r));
		req_credits--;
		issued++;
		step_cycle(1'b1, r);
	endtask

	task automatic bus_write(input logic [PAGE_W-1:0] page, input logic [OFFS_W-1:0] offs,
		input logic [DATA_W-1:0] data);
		bus_req_t r;
		r.addr  = {page, offs, 2'b00};
		r.wdata = data;
		r.sel   = '1;
		r.we    = 1'b1;
		issue(r);
	endtask

	task automatic bus_read(input logic [PAGE_W-1:0] page, input logic [OFFS_W-1:0] offs);
		bus_req_t r;
		r.addr  = {page, offs, 2'b00};
		r.wdata = '0;
		r.sel   = '1;
		r.we    = 1'b0;
		issue(r);
	endtask

	// Returns on a falling edge with all responses in
	task automatic wait_drain();
		while (exp_q.size() != 0)
			step_cycle(1'b0, '0);
		@(negedge clk);
	endtask

	// RAM fill word, spread over the whole word index
	function automatic logic [DATA_W-1:0] fill_word(input logic [7:0] w);
		return {~w, w, w ^ 8'h5a, w + 8'hc3};
	endfunction

	// ----------------------------------------
	// Monitor, sampled on the falling edge
	// ----------------------------------------
	always @(negedge clk) begin
		if (arst_n_i) begin
			cycles++;
			if (cycles > 10 * issued + 2000) begin
				$display("timeout with %0d responses outstanding", exp_q.size());
				$display("Result: FAILED");
				$fatal(1, "run exceeded its cycle limit");
			end else begin
				if (req_credit_o)
					req_credits++;
				if (req_credits > REQ_DEPTH)
					stop_on_error("request credits returned beyond the buffer depth");
				// Credit driven last cycle is taken by the DUT now
				if (credit_prev)
					rsp_debt--;
				credit_prev = rsp_credit_i;
				if (rsp_valid_o) begin
					rsp_debt++;
					owed++;
					check_rsp(rsp_o);
				end
				if (rsp_debt > RSP_CREDITS)
					stop_on_error("response sent without a response credit");
			end
		end
	end

	initial begin : main
		bus_req_t          r;
		logic [PAGE_W-1:0] page;
		logic [GPIO_W-1:0] v;
		logic [DATA_W-1:0] cmp;
		irq_t              exp_irq;
		logic              seen;
		lfsr         = 16'd33346;
		req_credits  = REQ_DEPTH;
		rsp_debt     = 0;
		owed         = 0;
		stall_left   = 0;
		issued       = 0;
		cycles       = 0;
		credit_prev  = 1'b0;
		model_reset();
		arst_n_i     = 1'b0;
		req_valid_i  = 1'b0;
		req_i        = '0;
		rsp_credit_i = 1'b0;
		gpio_in_i    = '0;
		repeat (8) @(posedge clk);
		arst_n_i <= 1'b1;
		@(negedge clk);
		if (rsp_valid_o || req_credit_o)
			stop_on_error("response or request credit active after reset");
		check_irq(irq_o, '0);
		check_gpio(gpio_out_o, '0);

		// Known contents in every RAM word
		for (int w = 0; w < BRAM_WORDS; w++)
			bus_write(PAGE_BRAM, OFFS_W'(w), fill_word(8'(w)));

		// ----------------------------------------
		// Random RAM and unmapped traffic
		// ----------------------------------------
		for (int n = 0; n < NUM_RAND; n++) begin
			if (rnd_bits(3) < 6) begin
				page = PAGE_BRAM;
			end else begin
				page = PAGE_W'(rnd_bits(PAGE_W));
				while (page == PAGE_BRAM || page == PAGE_TIMER || page == PAGE_GPIO)
					page = PAGE_W'(rnd_bits(PAGE_W));
			end
			// Offset above the lane bits wraps onto the RAM
			r.addr  = {page, 12'(rnd_bits(12))};
			r.wdata = rnd_bits(DATA_W);
			r.sel   = SEL_W'(rnd_bits(SEL_W));
			r.we    = rnd_bits(1);
			issue(r);
		end
		wait_drain();

		// GPIO out, in and masked interrupt
		for (int k = 0; k < 4; k++) begin
			v = GPIO_W'(rnd_bits(GPIO_W));
			bus_write(PAGE_GPIO, GPIO_OUT, v);
			wait_drain();
			check_gpio(gpio_out_o, v);
			gpio_in_m = GPIO_W'(rnd_bits(GPIO_W));
			repeat (4) step_cycle(1'b0, '0);
			bus_read(PAGE_GPIO, GPIO_IN);
			bus_write(PAGE_GPIO, GPIO_MASK, rnd_bits(GPIO_W));
			bus_read(PAGE_GPIO, GPIO_MASK);
			bus_read(PAGE_GPIO, GPIO_OUT);
			wait_drain();
			repeat (4) step_cycle(1'b0, '0);
			@(negedge clk);
			exp_irq           = '0;
			exp_irq[IRQ_GPIO] = |(gpio_in_m & gpio_mask_m);
			check_irq(irq_o, exp_irq);
		end
		bus_write(PAGE_GPIO, GPIO_MASK, '0);

		// ----------------------------------------
		// Timer compare and status clear
		// ----------------------------------------
		cmp = 8 + rnd_bits(4);
		bus_write(PAGE_TIMER, TMR_COMPARE, cmp);
		bus_read(PAGE_TIMER, TMR_COMPARE);
		bus_write(PAGE_TIMER, TMR_CTRL, 32'd1);
		seen = 1'b0;
		while (!seen) begin
			step_cycle(1'b0, '0);
			@(negedge clk);
			seen = irq_o[IRQ_TIMER];
		end
		exp_irq            = '0;
		exp_irq[IRQ_TIMER] = 1'b1;
		check_irq(irq_o, exp_irq);
		bus_write(PAGE_TIMER, TMR_CTRL, '0);
		bus_write(PAGE_TIMER, TMR_STATUS, rnd_bits(DATA_W));
		bus_read(PAGE_TIMER, TMR_STATUS);
		bus_read(PAGE_TIMER, TMR_CTRL);
		wait_drain();
		check_irq(irq_o, '0);

		// Quiet tail, any stray response fails in the monitor
		repeat (20) step_cycle(1'b0, '0);
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- soc_bus_top.f
+incdir+dv
design/soc_pkg.sv
design/credit_fifo.sv
design/page_router.sv
design/bram_slave.sv
design/timer_slave.sv
design/gpio_slave.sv
design/soc_bus_top.sv
dv/soc_tb.sv
